// ==== logic/vec_pkg.sv ====
/*
 * Shared types for the vector engine and its testbench.
 * Elements, addresses, opcodes, the command word and memory requests.
 */

package vec_pkg;

    // ============================================================
    // Data and address types
    // ============================================================
    typedef logic signed [7:0] elem_t;
    typedef logic [15:0]       addr_t;

    // Saturation limits for one element
    localparam elem_t ELEM_MAX = elem_t'(127);
    localparam elem_t ELEM_MIN = elem_t'(-128);

    // ============================================================
    // Vector opcodes and command word
    // ============================================================
    typedef enum logic [1:0] {
        VEC_ADD   = 2'd0,
        VEC_MUL   = 2'd1,
        VEC_SCALE = 2'd2,
        VEC_RELU  = 2'd3
    } vec_op_e;

    typedef struct packed {
        vec_op_e     opcode;
        logic [15:0] length;
        addr_t       src0_base;
        addr_t       src1_base;
        addr_t       dst_base;
        elem_t       scale;
        logic [3:0]  shift;
    } vec_cmd_t;

    // ============================================================
    // Memory port requests
    // ============================================================
    typedef struct packed {
        logic  en;
        addr_t addr;
        elem_t data;
    } mem_wr_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_t;

endpackage

// ==== logic/sram_dp.sv ====
/*
 * Element memory with one registered read port and one write port.
 * Read data appears one cycle after the enable; a same-cycle write
 * to the read address returns the old contents.
 */
`timescale 1ns/1ps

module sram_dp #(
    parameter int DEPTH = 1024
) (
    input  logic             clk,
    input  vec_pkg::mem_rd_t rd_i,
    output vec_pkg::elem_t   rd_data_o,
    input  vec_pkg::mem_wr_t wr_i
);

    localparam int ADDR_W = $clog2(DEPTH);

    vec_pkg::elem_t mem [DEPTH];

    // Only the low address bits select a word
    always_ff @(posedge clk) begin
        if (rd_i.en) begin
            rd_data_o <= mem[rd_i.addr[ADDR_W-1:0]];
        end
        if (wr_i.en) begin
            mem[wr_i.addr[ADDR_W-1:0]] <= wr_i.data;
        end
    end

    a_addr_in_range: assert property (@(posedge clk)
        !(rd_i.en && (rd_i.addr >= DEPTH)) && !(wr_i.en && (wr_i.addr >= DEPTH)))
        else $error("sram_dp access beyond depth %0d", DEPTH);

endmodule

// ==== logic/vec_alu.sv ====
/*
 * Registered element-wise ALU for the vector engine.
 * One result per cycle, one cycle of latency, saturated to 8 bits.
 */
`timescale 1ns/1ps

module vec_alu (
    input  logic             clk,
    input  logic             rst_i,
    input  vec_pkg::vec_op_e op_i,
    input  vec_pkg::elem_t   a_i,
    input  vec_pkg::elem_t   b_i,
    input  vec_pkg::elem_t   scale_i,
    input  logic [3:0]       shift_i,
    input  logic             valid_i,
    output vec_pkg::elem_t   res_o,
    output logic             valid_o
);

    // Clamp a wide signed value into the element range
    function automatic vec_pkg::elem_t clamp(input logic signed [15:0] v);
        if (v > vec_pkg::ELEM_MAX) begin
            return vec_pkg::ELEM_MAX;
        end else if (v < vec_pkg::ELEM_MIN) begin
            return vec_pkg::ELEM_MIN;
        end
        return vec_pkg::elem_t'(v[7:0]);
    endfunction

    vec_pkg::elem_t     mul_src;
    vec_pkg::elem_t     next_res;
    logic signed [15:0] prod;
    logic signed [15:0] shifted;
    logic signed [8:0]  sum;

    // ============================================================
    // Combinational result
    // ============================================================
    always_comb begin
        // Scale reuses the multiplier with the command constant
        mul_src = (op_i == vec_pkg::VEC_SCALE) ? scale_i : b_i;
        prod    = a_i * mul_src;
        shifted = prod >>> shift_i;
        sum     = a_i + b_i;
        case (op_i)
            vec_pkg::VEC_ADD:   next_res = clamp(sum);
            vec_pkg::VEC_MUL:   next_res = clamp(shifted);
            vec_pkg::VEC_SCALE: next_res = clamp(shifted);
            vec_pkg::VEC_RELU:  next_res = a_i[7] ? '0 : a_i;
            default:            next_res = '0;
        endcase
    end

    // ============================================================
    // Output registers
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        res_o <= next_res;
    end

endmodule

// ==== logic/vec_engine.sv ====
/*
 * Vector engine. Takes one command, streams both source vectors
 * through the ALU and writes results to data memory 0.
 * Read, compute and write overlap, so one element retires per cycle.
 */
`timescale 1ns/1ps

module vec_engine (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              cmd_valid_i,
    input  vec_pkg::vec_cmd_t cmd_i,
    output vec_pkg::mem_rd_t  rd0_o,
    output vec_pkg::mem_rd_t  rd1_o,
    input  vec_pkg::elem_t    rd0_data_i,
    input  vec_pkg::elem_t    rd1_data_i,
    output vec_pkg::mem_wr_t  wr_o,
    output logic              busy_o,
    output logic              done_o
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } state_e;

    state_e            state;
    vec_pkg::vec_cmd_t cmd_q;
    logic [15:0]       issue_cnt;
    logic              accept;
    logic              rd_v1;
    logic              done_q;
    vec_pkg::addr_t    dst_a1;
    vec_pkg::addr_t    dst_a2;
    vec_pkg::elem_t    alu_res;
    logic              alu_valid;

    assign accept = cmd_valid_i && (state == IDLE);
    assign busy_o = (state != IDLE);
    assign done_o = done_q;

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state     <= IDLE;
            issue_cnt <= '0;
            rd_v1     <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            // Read data is valid the cycle after a read is issued
            rd_v1  <= (state == RUN);
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        issue_cnt <= '0;
                        // Empty vector skips straight to the drain check
                        state     <= (cmd_i.length == 16'd0) ? DRAIN : RUN;
                    end
                end
                RUN: begin
                    issue_cnt <= issue_cnt + 16'd1;
                    if (issue_cnt == cmd_q.length - 16'd1) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    // Last result is on the write port this cycle
                    if (!rd_v1) begin
                        state  <= IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Command and destination address payload
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd_i;
        end
        dst_a1 <= cmd_q.dst_base + issue_cnt;
        dst_a2 <= dst_a1;
    end

    // ============================================================
    // Read requests and ALU
    // ============================================================
    always_comb begin
        rd0_o.en   = (state == RUN);
        rd0_o.addr = cmd_q.src0_base + issue_cnt;
        rd1_o.en   = (state == RUN);
        rd1_o.addr = cmd_q.src1_base + issue_cnt;
    end

    vec_alu u_alu (
        .clk     (clk),
        .rst_i   (rst_i),
        .op_i    (cmd_q.opcode),
        .a_i     (rd0_data_i),
        .b_i     (rd1_data_i),
        .scale_i (cmd_q.scale),
        .shift_i (cmd_q.shift),
        .valid_i (rd_v1),
        .res_o   (alu_res),
        .valid_o (alu_valid)
    );

    always_comb begin
        wr_o.en   = alu_valid;
        wr_o.addr = dst_a2;
        wr_o.data = alu_res;
    end

    a_wr_while_busy: assert property (@(posedge clk) disable iff (rst_i)
        wr_o.en |-> busy_o)
        else $error("vec_engine write outside busy window");

    a_done_pulse: assert property (@(posedge clk) disable iff (rst_i)
        done_o |=> !done_o)
        else $error("vec_engine done held longer than one cycle");

endmodule

// ==== logic/engine_top.sv ====
/*
 * Top level with two data memories and the vector engine.
 * The host owns the memory ports while the engine is idle; the engine
 * takes read ports and the memory 0 write port while busy.
 */
`timescale 1ns/1ps

module engine_top #(
    parameter int DEPTH = 1024
) (
    input  logic              clk,
    input  logic              rst_i,
    // Host memory access
    input  vec_pkg::mem_wr_t  host_wr0_i,
    input  vec_pkg::mem_wr_t  host_wr1_i,
    input  vec_pkg::mem_rd_t  host_rd0_i,
    input  vec_pkg::mem_rd_t  host_rd1_i,
    output vec_pkg::elem_t    host_rd0_data_o,
    output vec_pkg::elem_t    host_rd1_data_o,
    // Command and status
    input  logic              cmd_valid_i,
    input  vec_pkg::vec_cmd_t cmd_i,
    output logic              busy_o,
    output logic              done_o
);

    vec_pkg::mem_rd_t eng_rd0;
    vec_pkg::mem_rd_t eng_rd1;
    vec_pkg::mem_wr_t eng_wr;
    vec_pkg::mem_rd_t rd0_sel;
    vec_pkg::mem_rd_t rd1_sel;
    vec_pkg::mem_wr_t wr0_sel;
    vec_pkg::elem_t   rd0_data;
    vec_pkg::elem_t   rd1_data;

    // ============================================================
    // Host or engine port selection
    // ============================================================
    always_comb begin
        if (busy_o) begin
            rd0_sel = eng_rd0;
            rd1_sel = eng_rd1;
            wr0_sel = eng_wr;
        end else begin
            rd0_sel = host_rd0_i;
            rd1_sel = host_rd1_i;
            wr0_sel = host_wr0_i;
        end
    end

    // Read data goes to both host and engine
    assign host_rd0_data_o = rd0_data;
    assign host_rd1_data_o = rd1_data;

    // ============================================================
    // Data memories
    // ============================================================
    sram_dp #(.DEPTH(DEPTH)) mem0 (
        .clk       (clk),
        .rd_i      (rd0_sel),
        .rd_data_o (rd0_data),
        .wr_i      (wr0_sel)
    );

    // Engine never writes memory 1
    sram_dp #(.DEPTH(DEPTH)) mem1 (
        .clk       (clk),
        .rd_i      (rd1_sel),
        .rd_data_o (rd1_data),
        .wr_i      (host_wr1_i)
    );

    // ============================================================
    // Vector engine
    // ============================================================
    vec_engine u_vec (
        .clk         (clk),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .rd0_o       (eng_rd0),
        .rd1_o       (eng_rd1),
        .rd0_data_i  (rd0_data),
        .rd1_data_i  (rd1_data),
        .wr_o        (eng_wr),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

endmodule

// ==== test/clk_gen.sv ====
/*
 * Clock and reset source for the vector engine testbench.
 * Reset is held high for the first RST_CYCLES rising edges.
 */
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge so the design sees a clean first cycle
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// ==== test/engine_tb.sv ====
/*
 * Testbench for engine_top. Reads vector tests from the data file, loads
 * both memories through the host ports, runs each command and checks
 * done timing, results and the host lockout while the engine is busy.
 */
`timescale 1ns/1ps

module engine_tb;

    localparam int    DEPTH      = 1024;
    localparam int    GUARD_ADDR = 1000;
    localparam int    GUARD_VAL  = 90;
    localparam string DATA_FILE  = "test/vec_testdata.txt";

    logic              clk;
    logic              rst;
    vec_pkg::mem_wr_t  host_wr0;
    vec_pkg::mem_wr_t  host_wr1;
    vec_pkg::mem_rd_t  host_rd0;
    vec_pkg::mem_rd_t  host_rd1;
    vec_pkg::elem_t    host_rd0_data;
    vec_pkg::elem_t    host_rd1_data;
    logic              cmd_valid;
    vec_pkg::vec_cmd_t cmd;
    logic              busy;
    logic              done;

    vec_pkg::vec_cmd_t tests[$];
    int                a_vals[$];
    int                b_vals[$];
    int                exp_mem0[int];
    int                exp_mem1[int];
    int                errors       = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;
    int                cycle_cnt    = 0;
    int                cycle_limit  = 0;

    clk_gen #(.PERIOD_NS(20), .RST_CYCLES(2)) u_clk (.clk_o(clk), .rst_o(rst));

    engine_top #(.DEPTH(DEPTH)) dut0 (
        .clk             (clk),
        .rst_i           (rst),
        .host_wr0_i      (host_wr0),
        .host_wr1_i      (host_wr1),
        .host_rd0_i      (host_rd0),
        .host_rd1_i      (host_rd1),
        .host_rd0_data_o (host_rd0_data),
        .host_rd1_data_o (host_rd1_data),
        .cmd_valid_i     (cmd_valid),
        .cmd_i           (cmd),
        .busy_o          (busy),
        .done_o          (done)
    );

    // ============================================================
    // Watchdog
    // ============================================================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // ============================================================
    // Reference model and checks
    // ============================================================
    function automatic int predict(input vec_pkg::vec_op_e op, input int a, input int b,
                                   input int scale, input int shift);
        int r;
        case (op)
            vec_pkg::VEC_ADD:   r = a + b;
            vec_pkg::VEC_MUL:   r = (a * b) >>> shift;
            vec_pkg::VEC_SCALE: r = (a * scale) >>> shift;
            default:            r = (a < 0) ? 0 : a;
        endcase
        if (r > 127) begin
            r = 127;
        end else if (r < -128) begin
            r = -128;
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic signed [31:0] got, input int exp);
        assert (got === exp)
        else begin
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    // Next line holding data; comment and blank lines are skipped
    function automatic string next_line(input int fd);
        string line;
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                return line;
            end
        end
        return "";
    endfunction

    task automatic load_tests(output bit ok);
        int                fd;
        int                n;
        int                op, len, s0, s1, d, sc, sh, a, b;
        string             line;
        vec_pkg::vec_cmd_t c;
        ok = 1'b1;
        cycle_limit = 10;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open test data file %s", DATA_FILE);
            ok = 1'b0;
        end else begin
            line = next_line(fd);
            while (ok && line != "") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d", op, len, s0, s1, d, sc, sh);
                if (n != 7) begin
                    $display("Malformed test header: %s", line);
                    ok = 1'b0;
                end else begin
                    c.opcode    = vec_pkg::vec_op_e'(op);
                    c.length    = 16'(len);
                    c.src0_base = vec_pkg::addr_t'(s0);
                    c.src1_base = vec_pkg::addr_t'(s1);
                    c.dst_base  = vec_pkg::addr_t'(d);
                    c.scale     = vec_pkg::elem_t'(sc);
                    c.shift     = 4'(sh);
                    tests.push_back(c);
                    cycle_limit += 3 * len + 20;
                    for (int k = 0; k < len; k++) begin
                        line = next_line(fd);
                        if ($sscanf(line, "%d %d", a, b) != 2) begin
                            $display("Missing element pair %0d of test %0d", k, tests.size());
                            ok = 1'b0;
                        end
                        a_vals.push_back(a);
                        b_vals.push_back(b);
                    end
                    line = next_line(fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // ============================================================
    // Host port and command tasks
    // ============================================================
    task automatic write_mems(input int addr0, input int a, input int addr1, input int b);
        @(negedge clk);
        host_wr0.en   = 1'b1;
        host_wr0.addr = vec_pkg::addr_t'(addr0);
        host_wr0.data = vec_pkg::elem_t'(a);
        host_wr1.en   = 1'b1;
        host_wr1.addr = vec_pkg::addr_t'(addr1);
        host_wr1.data = vec_pkg::elem_t'(b);
        exp_mem0[addr0] = a;
        exp_mem1[addr1] = b;
    endtask

    // Pipelined reads of memory 0, one per cycle, compared where a value is known
    task automatic read_check0(input int base, input int n);
        for (int k = 0; k <= n; k++) begin
            @(negedge clk);
            if (k > 0 && exp_mem0.exists(base + k - 1)) begin
                check_val($sformatf("host_rd0_data_o mem0[%0d]", base + k - 1),
                          host_rd0_data, exp_mem0[base + k - 1]);
            end
            host_rd0.en   = (k < n);
            host_rd0.addr = vec_pkg::addr_t'(base + k);
        end
        host_rd0.en = 1'b0;
    endtask

    // Same read-back through the memory 1 host port
    task automatic read_check1(input int base, input int n);
        for (int k = 0; k <= n; k++) begin
            @(negedge clk);
            if (k > 0 && exp_mem1.exists(base + k - 1)) begin
                check_val($sformatf("host_rd1_data_o mem1[%0d]", base + k - 1),
                          host_rd1_data, exp_mem1[base + k - 1]);
            end
            host_rd1.en   = (k < n);
            host_rd1.addr = vec_pkg::addr_t'(base + k);
        end
        host_rd1.en = 1'b0;
    endtask

    task automatic run_command(input vec_pkg::vec_cmd_t c, output int cycles);
        int len;
        int expect_cycles;
        bit seen_done;
        len = int'(c.length);
        expect_cycles = (len == 0) ? 2 : len + 3;
        cycles = 0;
        seen_done = 1'b0;
        @(negedge clk);
        host_wr0.en = 1'b0;
        host_wr1.en = 1'b0;
        check_val("busy_o before command", busy, 0);
        cmd       = c;
        cmd_valid = 1'b1;
        while (!seen_done && cycles < expect_cycles + 8) begin
            @(negedge clk);
            cycles++;
            // Host write and a second strobe, both issued while busy
            if (cycles == 1) begin
                cmd_valid     = 1'b0;
                host_wr0.en   = 1'b1;
                host_wr0.addr = vec_pkg::addr_t'(GUARD_ADDR);
                host_wr0.data = vec_pkg::elem_t'(-GUARD_VAL);
            end else if (cycles == 2) begin
                host_wr0.en = 1'b0;
                cmd_valid   = (len > 0);
            end else begin
                cmd_valid = 1'b0;
            end
            if (done) begin
                seen_done = 1'b1;
                check_val("busy_o at done", busy, 0);
                check_val("done_o cycle count", cycles, expect_cycles);
            end else begin
                check_val("busy_o", busy, 1);
            end
        end
        cmd_valid = 1'b0;
        if (!seen_done) begin
            $display("done_o never arrived after %0d cycles", cycles);
            errors++;
        end
        // A dropped strobe must not start a second run
        repeat (3) begin
            @(negedge clk);
            check_val("done_o after done", done, 0);
            check_val("busy_o after done", busy, 0);
        end
    endtask

    task automatic run_test(input int idx, input int first);
        vec_pkg::vec_cmd_t c;
        int len;
        int dst;
        int cycles;
        int errs_before;
        c = tests[idx];
        len = int'(c.length);
        dst = int'(c.dst_base);
        errs_before = errors;
        for (int k = 0; k < len; k++) begin
            write_mems(int'(c.src0_base) + k, a_vals[first + k],
                       int'(c.src1_base) + k, b_vals[first + k]);
        end
        run_command(c, cycles);
        for (int k = 0; k < len; k++) begin
            exp_mem0[dst + k] = predict(c.opcode, a_vals[first + k], b_vals[first + k],
                                        int'(c.scale), int'(c.shift));
        end
        // An empty command is checked against the words already at dst
        read_check0(dst, (len == 0) ? 4 : len);
        read_check0(GUARD_ADDR, 1);
        read_check1(int'(c.src1_base), len);
        if (errors == errs_before) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("Test %0d %s length %0d: %s, done after %0d cycles", idx,
                 c.opcode.name(), len, (errors == errs_before) ? "pass" : "FAIL", cycles);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        bit ok;
        int first;
        host_wr0  = '0;
        host_wr1  = '0;
        host_rd0  = '0;
        host_rd1  = '0;
        cmd       = '0;
        cmd_valid = 1'b0;
        first     = 0;
        load_tests(ok);
        if (!ok) begin
            $display("Test data could not be read");
            errors++;
        end else begin
            @(negedge rst);
            write_mems(GUARD_ADDR, GUARD_VAL, GUARD_ADDR, 0);
            for (int t = 0; t < tests.size(); t++) begin
                run_test(t, first);
                first += int'(tests[t].length);
            end
        end
        $display("Tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== test/vec_testdata.txt ====
# Header: opcode(0 add, 1 mul, 2 scale, 3 relu) length src0 src1 dst scale shift
# Followed by length lines of: a b  (signed decimal elements)
0 4 0 0 100 0 0
100 100
-100 -100
20 -7
-5 3
1 4 10 10 110 0 2
7 -3
-9 5
100 100
-128 127
2 3 20 20 120 -5 0
10 99
-30 -77
60 5
2 3 30 30 130 9 3
13 -1
-7 44
120 0
3 4 40 40 140 0 0
-1 8
0 -8
127 1
-128 0
0 0 50 50 100 0 0

// ==== sim.f ====
logic/vec_pkg.sv
logic/sram_dp.sv
logic/vec_alu.sv
logic/vec_engine.sv
logic/engine_top.sv
test/clk_gen.sv
test/engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector engine testbench with Verilator.
# Exits non-zero if the build or run fails or the log reports failure.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module engine_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vengine_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation passed"
exit 0
